// File: all.f
+incdir+test
source/gemm_pkg.sv
source/gemm_pe.sv
source/gemm_row.sv
source/gemm_cfg_regs.sv
source/gemm_row_top.sv
test/tb_gemm_row.sv

// File: run_verilator.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass message
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gemm_row -f all.f -o sim_gemm_row

./obj_dir/sim_gemm_row | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: source/gemm_cfg_regs.sv
// zero wait state APB slave; weights, bias and enable are written only while the row is empty
`timescale 1ns/1ns
`default_nettype none

module gemm_cfg_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // apb slave
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  gemm_pkg::apb_addr_t                   paddr_i,
  input  gemm_pkg::apb_data_t                   pwdata_i,
  output gemm_pkg::apb_data_t                   prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  // row side
  input  logic                                  result_fire_i,
  output logic                                  enable_o,
  output gemm_pkg::acc_t                        bias_o,
  output gemm_pkg::data_t [gemm_pkg::NumPe-1:0] weights_o
);

  logic                                  access;
  logic                                  aligned;
  logic                                  hit_ctrl;
  logic                                  hit_bias;
  logic                                  hit_status;
  logic                                  hit_weight;
  logic                                  bad_access;
  logic                                  wr_en;
  gemm_pkg::apb_addr_t                   weight_off;
  logic [gemm_pkg::PeIdxW-1:0]           widx;

  logic                                  enable_q;
  gemm_pkg::acc_t                        bias_q;
  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] weights_q;
  gemm_pkg::apb_data_t                   count_q;

  assign access  = psel_i && penable_i;
  assign aligned = (paddr_i[1:0] == 2'b00);

  // exact compares also reject misaligned offsets
  assign hit_ctrl   = (paddr_i == gemm_pkg::CtrlOffs);
  assign hit_bias   = (paddr_i == gemm_pkg::BiasOffs);
  assign hit_status = (paddr_i == gemm_pkg::StatusOffs);
  assign hit_weight = aligned && (paddr_i >= gemm_pkg::WeightBase) &&
                      (paddr_i < gemm_pkg::WeightEnd);

  assign weight_off = paddr_i - gemm_pkg::WeightBase;
  assign widx       = weight_off[gemm_pkg::PeIdxW+1:2];

  // unmapped, misaligned, or a write to status
  assign bad_access = !(hit_ctrl || hit_bias || hit_status || hit_weight) ||
                      (pwrite_i && hit_status);

  assign wr_en     = access && pwrite_i && !bad_access;
  assign pready_o  = 1'b1;
  assign pslverr_o = access && bad_access;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q  <= 1'b0;
      bias_q    <= '0;
      weights_q <= '0;
    end else if (wr_en) begin
      if (hit_ctrl) begin
        enable_q <= pwdata_i[0];
      end
      if (hit_bias) begin
        bias_q <= gemm_pkg::acc_t'(pwdata_i);
      end
      if (hit_weight) begin
        weights_q[widx] <= pwdata_i[gemm_pkg::DataW-1:0];  // upper half dropped
      end
    end
  end

  // wraps at 2^32
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (result_fire_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (hit_ctrl) begin
      prdata_o = {{(gemm_pkg::ApbDataW-1){1'b0}}, enable_q};
    end else if (hit_bias) begin
      prdata_o = gemm_pkg::apb_data_t'(bias_q);
    end else if (hit_status) begin
      prdata_o = count_q;
    end else if (hit_weight) begin
      prdata_o = {{(gemm_pkg::ApbDataW-gemm_pkg::DataW){1'b0}}, weights_q[widx]};
    end
  end

  assign enable_o  = enable_q;
  assign bias_o    = bias_q;
  assign weights_o = weights_q;

  // access phase always follows a selected cycle
  apb_phase_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i && $past(psel_i));

endmodule

`default_nettype wire

// File: source/gemm_pe.sv
// the sum saturates at the acc_t limits instead of wrapping; NumPe must be at least 2
`timescale 1ns/1ns
`default_nettype none

module gemm_pe (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  adv_i,     // shared row advance
  input  logic                                  valid_i,
  input  gemm_pkg::acc_t                        acc_i,     // sum from previous stage
  input  gemm_pkg::data_t                       act_i,
  input  gemm_pkg::data_t                       weight_i,
  input  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] rest_i,
  output logic                                  valid_o,
  output gemm_pkg::acc_t                        acc_o,
  output gemm_pkg::data_t [gemm_pkg::NumPe-1:0] rest_o
);

  gemm_pkg::acc_t                        prod;
  logic [gemm_pkg::AccW:0]               sum_wide;
  gemm_pkg::acc_t                        sum_sat;
  logic                                  valid_q;
  gemm_pkg::acc_t                        acc_q;
  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] rest_q;

  // 16x16 signed always fits in 32 bits
  assign prod = act_i * weight_i;

  // one guard bit catches the overflow
  assign sum_wide = {acc_i[gemm_pkg::AccW-1], acc_i} + {prod[gemm_pkg::AccW-1], prod};

  always_comb begin
    if (sum_wide[gemm_pkg::AccW] != sum_wide[gemm_pkg::AccW-1]) begin
      sum_sat = sum_wide[gemm_pkg::AccW] ? gemm_pkg::AccMin : gemm_pkg::AccMax;
    end else begin
      sum_sat = sum_wide[gemm_pkg::AccW-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (adv_i) begin
      valid_q <= valid_i;
    end
  end

  // next stage finds its activation in element 0
  always_ff @(posedge clk_i) begin
    if (adv_i) begin
      acc_q  <= sum_sat;
      rest_q <= {gemm_pkg::data_t'(0), rest_i[gemm_pkg::NumPe-1:1]};
    end
  end

  assign valid_o = valid_q;
  assign acc_o   = acc_q;
  assign rest_o  = rest_q;

  // operands of one sign keep that sign through the saturating add
  sat_sign_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    adv_i && valid_i && (acc_i[gemm_pkg::AccW-1] == prod[gemm_pkg::AccW-1])
    |=> acc_o[gemm_pkg::AccW-1] == $past(acc_i[gemm_pkg::AccW-1]));

endmodule

`default_nettype wire

// File: source/gemm_pkg.sv
// NumPe must be at least 2, and the weight window has to end below 0x100 of the APB space
`default_nettype none

package gemm_pkg;

  // row geometry
  localparam int unsigned NumPe    = 4;
  localparam int unsigned DataW    = 16;
  localparam int unsigned AccW     = 32;
  localparam int unsigned PeIdxW   = (NumPe > 1) ? $clog2(NumPe) : 1;

  // apb side
  localparam int unsigned AddrW    = 8;
  localparam int unsigned ApbDataW = 32;

  typedef logic signed [DataW-1:0] data_t;    // activation or weight
  typedef logic signed [AccW-1:0]  acc_t;     // partial sum, result, bias
  typedef logic [AddrW-1:0]        apb_addr_t;
  typedef logic [ApbDataW-1:0]     apb_data_t;

  // register map, byte offsets
  localparam apb_addr_t CtrlOffs   = 8'h00;   // bit 0 enable
  localparam apb_addr_t BiasOffs   = 8'h04;
  localparam apb_addr_t StatusOffs = 8'h08;   // result count, read only
  localparam apb_addr_t WeightBase = 8'h10;

  // first offset past the last weight
  localparam apb_addr_t WeightEnd  = WeightBase + apb_addr_t'(4 * NumPe);

  // saturation limits
  localparam acc_t AccMax = {1'b0, {(AccW-1){1'b1}}};
  localparam acc_t AccMin = {1'b1, {(AccW-1){1'b0}}};

endpackage

`default_nettype wire

// File: source/gemm_row.sv
// all stages stall together; one result per cycle while z_ready_i stays high
`timescale 1ns/1ns
`default_nettype none

module gemm_row (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  enable_i,
  input  gemm_pkg::acc_t                        bias_i,
  input  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] weights_i,
  // input vectors
  input  logic                                  x_valid_i,
  input  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] x_data_i,
  output logic                                  x_ready_o,
  // dot product results
  output logic                                  z_valid_o,
  output gemm_pkg::acc_t                        z_data_o,
  input  logic                                  z_ready_i,
  output logic                                  result_fire_o
);

  logic adv;
  logic x_fire;

  // index k is the input of PE k, index NumPe the row output
  logic [gemm_pkg::NumPe:0]                                     valid_c;
  gemm_pkg::acc_t [gemm_pkg::NumPe:0]                           acc_c;
  gemm_pkg::data_t [gemm_pkg::NumPe:0][gemm_pkg::NumPe-1:0]     rest_c;

  // move when the output slot is empty or being taken
  assign adv       = !z_valid_o || z_ready_i;
  assign x_ready_o = enable_i && adv;
  assign x_fire    = x_valid_i && x_ready_o;

  assign valid_c[0] = x_fire;
  assign acc_c[0]   = bias_i;    // first stage starts from the bias
  assign rest_c[0]  = x_data_i;

  for (genvar k = 0; k < gemm_pkg::NumPe; k++) begin : gen_pe
    gemm_pe u_pe (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .adv_i    (adv),
      .valid_i  (valid_c[k]),
      .acc_i    (acc_c[k]),
      .act_i    (rest_c[k][0]),
      .weight_i (weights_i[k]),
      .rest_i   (rest_c[k]),
      .valid_o  (valid_c[k+1]),
      .acc_o    (acc_c[k+1]),
      .rest_o   (rest_c[k+1])
    );
  end

  assign z_valid_o     = valid_c[gemm_pkg::NumPe];
  assign z_data_o      = acc_c[gemm_pkg::NumPe];
  assign result_fire_o = z_valid_o && z_ready_i;

  // result held until the consumer takes it
  z_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_valid_o && !z_ready_i |=> z_valid_o && $stable(z_data_o));

  // source keeps its vector until accepted
  x_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_valid_i && !x_ready_o |=> x_valid_i && $stable(x_data_i));

endmodule

`default_nettype wire

// File: source/gemm_row_top.sv
// software keeps weights, bias and enable fixed while any vector is still in the row
`timescale 1ns/1ns
`default_nettype none

module gemm_row_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // apb slave
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  gemm_pkg::apb_addr_t                   paddr_i,
  input  gemm_pkg::apb_data_t                   pwdata_i,
  output gemm_pkg::apb_data_t                   prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  // vector streams
  input  logic                                  x_valid_i,
  input  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] x_data_i,
  output logic                                  x_ready_o,
  output logic                                  z_valid_o,
  output gemm_pkg::acc_t                        z_data_o,
  input  logic                                  z_ready_i
);

  logic                                  enable;
  gemm_pkg::acc_t                        bias;
  gemm_pkg::data_t [gemm_pkg::NumPe-1:0] weights;
  logic                                  result_fire;

  gemm_cfg_regs u_cfg_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .result_fire_i (result_fire),
    .enable_o      (enable),
    .bias_o        (bias),
    .weights_o     (weights)
  );

  gemm_row u_row (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable),
    .bias_i        (bias),
    .weights_i     (weights),
    .x_valid_i     (x_valid_i),
    .x_data_i      (x_data_i),
    .x_ready_o     (x_ready_o),
    .z_valid_o     (z_valid_o),
    .z_data_o      (z_data_o),
    .z_ready_i     (z_ready_i),
    .result_fire_o (result_fire)  // counted in status
  );

endmodule

`default_nettype wire

// File: test/gemm_model.svh
// include inside the testbench module; sums assume weights and bias change only with the row empty
`ifndef GEMM_MODEL_SVH
`define GEMM_MODEL_SVH

// last values written over APB, reset values to start
gemm_pkg::acc_t  model_bias = '0;
gemm_pkg::data_t model_w [gemm_pkg::NumPe] = '{default: '0};

// one entry per accepted vector, oldest first
gemm_pkg::acc_t  exp_q [$];

// clamp a wide sum into the acc_t range
function automatic gemm_pkg::acc_t clip_sum(input longint s);
  if (s > longint'(gemm_pkg::AccMax)) begin
    return gemm_pkg::AccMax;
  end
  if (s < longint'(gemm_pkg::AccMin)) begin
    return gemm_pkg::AccMin;
  end
  return gemm_pkg::acc_t'(s);
endfunction

// bias first, then PE 0 up to the last PE, clipping after every add
function automatic gemm_pkg::acc_t expected_sum(
  input gemm_pkg::data_t [gemm_pkg::NumPe-1:0] x
);
  longint s;
  s = longint'(model_bias);
  for (int k = 0; k < gemm_pkg::NumPe; k++) begin
    s = clip_sum(s + longint'(x[k]) * longint'(model_w[k]));
  end
  return gemm_pkg::acc_t'(s);
endfunction

function automatic void push_expected(input gemm_pkg::data_t [gemm_pkg::NumPe-1:0] x);
  exp_q.push_back(expected_sum(x));
endfunction

`endif

// File: test/tb_gemm_row.sv
// inputs change on the falling edge and outputs are sampled at the rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_gemm_row;

  localparam int NumStream     = 200;
  localparam int NumBp         = 200;
  localparam int NumSatPerBias = 16;
  localparam int NumNew        = 20;
  localparam int TotalVec      = NumStream + NumBp + 2 * NumSatPerBias + NumNew;
  localparam int TimeoutCycles = TotalVec * (gemm_pkg::NumPe + 8) + 600;

  typedef gemm_pkg::data_t [gemm_pkg::NumPe-1:0] vec_t;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  gemm_pkg::apb_addr_t paddr;
  gemm_pkg::apb_data_t pwdata;
  gemm_pkg::apb_data_t prdata;
  logic                pready;
  logic                pslverr;
  logic                x_valid;
  vec_t                x_data;
  logic                x_ready;
  logic                z_valid;
  gemm_pkg::acc_t      z_data;
  logic                z_ready;

  int             errors    = 0;
  int             checks    = 0;
  int             cycles    = 0;
  int             in_count  = 0;
  int             out_count = 0;
  int             in_cycle_q [$];
  logic           held      = 1'b0;
  gemm_pkg::acc_t held_data;
  logic           lat_check = 1'b0;  // only while the output never stalls
  logic           bp_done;

  `include "gemm_model.svh"

  gemm_row_top u_gemm_row_top (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .x_valid_i (x_valid),
    .x_data_i  (x_data),
    .x_ready_o (x_ready),
    .z_valid_o (z_valid),
    .z_data_o  (z_data),
    .z_ready_i (z_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    for (int n = 0; n < TimeoutCycles; n++) @(posedge clk);
    $display("timeout after %0d cycles, the stream did not drain", TimeoutCycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_acc(input string name, input gemm_pkg::acc_t got,
                           input gemm_pkg::acc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_apb_data(input string name, input gemm_pkg::apb_data_t got,
                                input gemm_pkg::apb_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // setup phase, access phase, then back to idle
  task automatic apb_transfer(input logic wr, input gemm_pkg::apb_addr_t a,
                              input gemm_pkg::apb_data_t wd,
                              output gemm_pkg::apb_data_t rd, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = wd;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    rd  = prdata;
    err = pslverr;
    check_bit("pready_o", pready, 1'b1);  // no wait states
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input gemm_pkg::apb_addr_t a, input gemm_pkg::apb_data_t d);
    gemm_pkg::apb_data_t rd;
    logic err;
    apb_transfer(1'b1, a, d, rd, err);
    check_bit("pslverr_o", err, 1'b0);
  endtask

  task automatic read_expect(input gemm_pkg::apb_addr_t a, input gemm_pkg::apb_data_t exp);
    gemm_pkg::apb_data_t rd;
    logic err;
    apb_transfer(1'b0, a, '0, rd, err);
    check_apb_data("prdata_o", rd, exp);
    check_bit("pslverr_o", err, 1'b0);
  endtask

  task automatic expect_bus_error(input logic wr, input gemm_pkg::apb_addr_t a);
    gemm_pkg::apb_data_t rd;
    logic err;
    apb_transfer(wr, a, $urandom, rd, err);
    check_bit("pslverr_o", err, 1'b1);
  endtask

  // junk in the upper half of each weight write must read back as zero
  task automatic load_config(input gemm_pkg::acc_t bias, input vec_t w);
    gemm_pkg::apb_addr_t wa;
    write_reg(gemm_pkg::BiasOffs, gemm_pkg::apb_data_t'(bias));
    model_bias = bias;
    for (int k = 0; k < gemm_pkg::NumPe; k++) begin
      wa = gemm_pkg::WeightBase + gemm_pkg::apb_addr_t'(4 * k);
      write_reg(wa, {16'($urandom), w[k]});
      model_w[k] = w[k];
    end
    read_expect(gemm_pkg::BiasOffs, gemm_pkg::apb_data_t'(bias));
    for (int k = 0; k < gemm_pkg::NumPe; k++) begin
      read_expect(gemm_pkg::WeightBase + gemm_pkg::apb_addr_t'(4 * k), {16'h0, w[k]});
    end
  endtask

  function automatic vec_t rand_vec();
    vec_t v;
    for (int k = 0; k < gemm_pkg::NumPe; k++) v[k] = gemm_pkg::data_t'($urandom);
    return v;
  endfunction

  function automatic vec_t extreme_vec();
    vec_t v;
    for (int k = 0; k < gemm_pkg::NumPe; k++) begin
      case ($urandom % 4)
        0:       v[k] = 16'h7fff;
        1:       v[k] = 16'h8000;
        2:       v[k] = 16'h8001;
        default: v[k] = gemm_pkg::data_t'($urandom);
      endcase
    end
    return v;
  endfunction

  // holds valid and data until the vector is taken
  task automatic send_vector(input vec_t v);
    @(negedge clk);
    x_valid = 1'b1;
    x_data  = v;
    do @(posedge clk); while (!x_ready);
  endtask

  task automatic end_vectors();
    @(negedge clk);
    x_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // handshakes, ordering, latency and hold checks
  always @(posedge clk) begin
    int lat;
    if (rst_n) begin
      cycles++;
      if (x_valid && x_ready) begin
        push_expected(x_data);
        in_cycle_q.push_back(cycles);
        in_count++;
      end else if (lat_check && x_valid) begin
        report_failure("input vector stalled while the output was always ready");
      end
      if (z_valid && z_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("result taken with no vector in flight");
        end else begin
          check_acc("z_data_o", z_data, exp_q.pop_front());
          lat = cycles - in_cycle_q.pop_front();
          if (lat_check && lat != gemm_pkg::NumPe) begin
            report_failure($sformatf("result came %0d cycles after its vector, expected %0d",
                                     lat, gemm_pkg::NumPe));
          end
        end
        out_count++;
      end
      if (held) begin
        check_bit("z_valid_o", z_valid, 1'b1);
        check_acc("z_data_o", z_data, held_data);
      end
      held      = z_valid && !z_ready;
      held_data = z_data;
    end
  end

  initial begin
    vec_t w;
    vec_t v;
    void'($urandom(32'hd9ef));
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    x_valid = 1'b0;
    x_data  = '0;
    z_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("x_ready_o", x_ready, 1'b0);
    check_bit("z_valid_o", z_valid, 1'b0);
    check_bit("pslverr_o", pslverr, 1'b0);

    // register access
    read_expect(gemm_pkg::StatusOffs, '0);
    read_expect(gemm_pkg::CtrlOffs, '0);
    load_config(gemm_pkg::acc_t'($urandom), rand_vec());
    check_bit("x_ready_o", x_ready, 1'b0);  // enable still clear

    // bus errors leave everything untouched
    expect_bus_error(1'b1, gemm_pkg::StatusOffs);
    expect_bus_error(1'b1, 8'h0c);
    expect_bus_error(1'b1, 8'h05);
    expect_bus_error(1'b1, 8'h12);
    expect_bus_error(1'b0, 8'h40);
    read_expect(gemm_pkg::StatusOffs, '0);
    read_expect(gemm_pkg::BiasOffs, gemm_pkg::apb_data_t'(model_bias));
    read_expect(gemm_pkg::WeightBase, {16'h0, model_w[0]});
    read_expect(gemm_pkg::CtrlOffs, '0);

    // streaming with no stalls
    write_reg(gemm_pkg::CtrlOffs, 32'h1);
    z_ready   = 1'b1;
    lat_check = 1'b1;
    repeat (NumStream) send_vector(rand_vec());
    end_vectors();
    wait_drain();
    lat_check = 1'b0;

    // random back-pressure and gaps
    bp_done = 1'b0;
    fork
      begin
        repeat (NumBp) begin
          send_vector(rand_vec());
          if ($urandom % 2 == 0) begin
            end_vectors();
            repeat ($urandom % 3) @(negedge clk);
          end
        end
        end_vectors();
        wait_drain();
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(negedge clk);
          z_ready = 1'($urandom % 2);
        end
      end
    join
    @(negedge clk);
    z_ready = 1'b1;

    // saturation near both limits
    w[0] = 16'h7fff;
    w[1] = 16'h7fff;
    w[2] = 16'h8000;
    w[3] = 16'h8000;
    for (int b = 0; b < 2; b++) begin
      load_config(b == 0 ? gemm_pkg::AccMax - 10 : gemm_pkg::AccMin + 10, w);
      v[0] = 16'h7fff;  // clips at PE 0 near the top
      v[1] = 16'h8000;  // back inside at PE 1
      v[2] = 16'h0001;
      v[3] = 16'h0000;
      send_vector(v);
      repeat (NumSatPerBias - 1) send_vector(extreme_vec());
      end_vectors();
      wait_drain();
    end

    // result counter, then new weights
    read_expect(gemm_pkg::StatusOffs, gemm_pkg::apb_data_t'(out_count));
    load_config(gemm_pkg::acc_t'($urandom), rand_vec());
    repeat (NumNew) send_vector(rand_vec());
    end_vectors();
    wait_drain();
    read_expect(gemm_pkg::StatusOffs, gemm_pkg::apb_data_t'(out_count));

    if (in_count != TotalVec || out_count != TotalVec) begin
      report_failure($sformatf("%0d vectors accepted and %0d results taken, expected %0d",
                               in_count, out_count, TotalVec));
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
